/* common/pe_config.svh */
`ifndef PE_CONFIG_SVH
`define PE_CONFIG_SVH

// flit and scratchpad word width
`define FLIT_WIDTH 16

// input fifo depth, equal to the credits an output starts with
`define BUF_DEPTH 4

`define MEM_DEPTH 256
`define MEM_ADDR_W 8

// mesh coordinates of this node
`define NODE_X 4'd1
`define NODE_Y 4'd1

`endif

/* common/pe_pkg.sv */
package pe_pkg;

  // router port index, also the index of the link pins
  typedef enum logic [2:0] {
    PORT_EAST  = 3'd0,
    PORT_WEST  = 3'd1,
    PORT_NORTH = 3'd2,
    PORT_SOUTH = 3'd3,
    PORT_LOCAL = 3'd4
  } port_e;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_HEADER,
    TX_READ,     // scratchpad read in flight
    TX_PAYLOAD
  } dma_tx_state_e;

  typedef enum logic {
    RX_IDLE,
    RX_PAYLOAD
  } dma_rx_state_e;

  // low bits of a register-space address
  typedef enum logic [2:0] {
    REG_SRC     = 3'd0,
    REG_LEN     = 3'd1,
    REG_DEST    = 3'd2,
    REG_CTRL    = 3'd3,
    REG_RX_BASE = 3'd4
  } reg_addr_e;

endpackage

/* router/router_input_buffer.sv */
`timescale 1ns/1ns
`include "pe_config.svh"

module router_input_buffer import pe_pkg::*; (
  input  logic                   clock,
  input  logic                   rst_n_i,
  input  logic                   rx_i,
  input  logic [`FLIT_WIDTH-1:0] data_i,
  output logic                   credit_o,
  input  logic                   pop_i,
  output logic                   head_valid_o,
  output logic [`FLIT_WIDTH-1:0] head_data_o,
  output port_e                  route_o,
  output logic                   head_is_last_o
);
  localparam int PW = $clog2(`BUF_DEPTH);

  logic [`FLIT_WIDTH-1:0] fifo_q [`BUF_DEPTH];
  logic [PW-1:0]          wr_ptr_q;
  logic [PW-1:0]          rd_ptr_q;
  logic [PW:0]            count_q;
  logic                   in_pkt_q;  // header already popped
  logic [7:0]             remain_q;  // payload flits still to pop
  port_e                  route_q;
  port_e                  route_new;
  logic [3:0]             dest_x;
  logic [3:0]             dest_y;

  assign head_valid_o   = count_q != '0;
  assign head_data_o    = fifo_q[rd_ptr_q];
  assign dest_x         = head_data_o[`FLIT_WIDTH-1 -: 4];
  assign dest_y         = head_data_o[`FLIT_WIDTH-5 -: 4];
  assign route_o        = in_pkt_q ? route_q : route_new;
  assign head_is_last_o = in_pkt_q && (remain_q == 8'd1);

  // xy routing, x first
  always_comb begin
    if (dest_x > `NODE_X)      route_new = PORT_EAST;
    else if (dest_x < `NODE_X) route_new = PORT_WEST;
    else if (dest_y > `NODE_Y) route_new = PORT_NORTH;
    else if (dest_y < `NODE_Y) route_new = PORT_SOUTH;
    else                       route_new = PORT_LOCAL;
  end

  always_ff @(posedge clock) begin
    if (rx_i) fifo_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
      in_pkt_q <= 1'b0;
      remain_q <= '0;
      route_q  <= PORT_EAST;
    end else begin
      credit_o <= pop_i;  // slot freed, hand it back upstream
      count_q  <= count_q + (PW+1)'(rx_i) - (PW+1)'(pop_i);
      if (rx_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
        if (!in_pkt_q) begin
          in_pkt_q <= 1'b1;
          remain_q <= head_data_o[7:0];
          route_q  <= route_new;
        end else begin
          remain_q <= remain_q - 8'd1;
          if (remain_q == 8'd1) in_pkt_q <= 1'b0;
        end
      end
    end
  end

endmodule

/* router/router.sv */
`timescale 1ns/1ns
`include "pe_config.svh"

module router import pe_pkg::*; (
  input  logic                        clock,
  input  logic                        rst_n_i,
  input  logic [4:0]                  rx_i,
  input  logic [4:0][`FLIT_WIDTH-1:0] data_i,
  output logic [4:0]                  credit_o,
  output logic [4:0]                  tx_o,
  output logic [4:0][`FLIT_WIDTH-1:0] data_o,
  input  logic [4:0]                  credit_i
);
  localparam int NP = 5;
  localparam int CW = $clog2(`BUF_DEPTH + 1);

  logic [NP-1:0]                  head_valid;
  logic [NP-1:0][`FLIT_WIDTH-1:0] head_data;
  port_e                          route [NP];
  logic [NP-1:0]                  is_last;
  logic [NP-1:0]                  pop;

  logic [NP-1:0] req [NP];       // req[out][in]
  logic [2:0]    sel [NP];       // input granted per output
  logic [NP-1:0] fire;           // output moves a flit this cycle
  logic [NP-1:0] locked_q;       // output held by a packet
  logic [2:0]    owner_q [NP];
  logic [2:0]    rr_q [NP];      // last packet winner
  logic [CW-1:0] credit_q [NP];  // free slots downstream

  for (genvar g = 0; g < NP; g++) begin : g_in
    router_input_buffer u_buf (
      .clock          (clock),
      .rst_n_i        (rst_n_i),
      .rx_i           (rx_i[g]),
      .data_i         (data_i[g]),
      .credit_o       (credit_o[g]),
      .pop_i          (pop[g]),
      .head_valid_o   (head_valid[g]),
      .head_data_o    (head_data[g]),
      .route_o        (route[g]),
      .head_is_last_o (is_last[g])
    );
  end

  // next requester after the last winner
  function automatic logic [2:0] rr_pick(input logic [NP-1:0] r, input logic [2:0] last);
    logic [2:0] idx;
    rr_pick = last;
    for (int k = NP; k >= 1; k--) begin
      idx = 3'((int'(last) + k) % NP);
      if (r[idx]) rr_pick = idx;
    end
  endfunction

  always_comb begin
    for (int o = 0; o < NP; o++) begin
      for (int i = 0; i < NP; i++) begin
        req[o][i] = head_valid[i] && (route[i] == port_e'(o));
      end
    end
  end

  always_comb begin
    pop = '0;
    for (int o = 0; o < NP; o++) begin
      sel[o]  = locked_q[o] ? owner_q[o] : rr_pick(req[o], rr_q[o]);
      fire[o] = req[o][sel[o]] && (credit_q[o] != '0);
      if (fire[o]) pop[sel[o]] = 1'b1;
    end
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_o     <= '0;
      locked_q <= '0;
      for (int o = 0; o < NP; o++) begin
        owner_q[o]  <= '0;
        rr_q[o]     <= '0;
        credit_q[o] <= CW'(`BUF_DEPTH);
      end
    end else begin
      tx_o <= fire;
      for (int o = 0; o < NP; o++) begin
        credit_q[o] <= credit_q[o] + CW'(credit_i[o]) - CW'(fire[o]);
        if (fire[o]) begin
          if (is_last[sel[o]]) begin
            locked_q[o] <= 1'b0;  // packet done, reopen arbitration
            rr_q[o]     <= sel[o];
          end else begin
            locked_q[o] <= 1'b1;
            owner_q[o]  <= sel[o];
          end
        end
      end
    end
  end

  // crossbar
  always_ff @(posedge clock) begin
    for (int o = 0; o < NP; o++) begin
      if (fire[o]) data_o[o] <= head_data[sel[o]];
    end
  end

endmodule

/* src/ddma.sv */
`timescale 1ns/1ns
`include "pe_config.svh"

module ddma import pe_pkg::*; (
  input  logic                   clock,
  input  logic                   rst_n_i,
  input  logic                   start_i,
  input  logic [`MEM_ADDR_W-1:0] src_i,
  input  logic [7:0]             len_i,
  input  logic [7:0]             dest_i,
  input  logic [`MEM_ADDR_W-1:0] rx_base_i,
  output logic                   busy_o,
  output logic                   rx_done_o,
  input  logic                   rx_clear_i,
  output logic                   tx_o,
  output logic [`FLIT_WIDTH-1:0] data_o,
  input  logic                   credit_i,
  input  logic                   rx_i,
  input  logic [`FLIT_WIDTH-1:0] data_i,
  output logic                   credit_o,
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output logic [`MEM_ADDR_W-1:0] mem_addr_o,
  output logic [`FLIT_WIDTH-1:0] mem_wdata_o,
  input  logic [`FLIT_WIDTH-1:0] mem_rdata_i
);
  localparam int CW = $clog2(`BUF_DEPTH + 1);

  dma_tx_state_e          tx_state_q;
  dma_rx_state_e          rx_state_q;
  logic [`MEM_ADDR_W-1:0] tx_addr_q;
  logic [`MEM_ADDR_W-1:0] rx_addr_q;
  logic [7:0]             tx_left_q;  // payload flits left to send
  logic [7:0]             rx_left_q;
  logic [7:0]             tx_dest_q;
  logic [CW-1:0]          tx_credit_q;
  logic                   tx_fire;
  logic                   tx_rd;
  logic                   rx_wr;

  assign busy_o  = tx_state_q != TX_IDLE;
  assign rx_wr   = (rx_state_q == RX_PAYLOAD) && rx_i;
  assign tx_rd   = (tx_state_q == TX_READ) && !rx_wr;  // receive owns port a first
  assign tx_fire = (tx_state_q inside {TX_HEADER, TX_PAYLOAD}) && (tx_credit_q != '0);

  assign mem_req_o   = rx_wr || tx_rd;
  assign mem_we_o    = rx_wr;
  assign mem_addr_o  = rx_wr ? rx_addr_q : tx_addr_q;
  assign mem_wdata_o = data_i;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_state_q  <= TX_IDLE;
      tx_addr_q   <= '0;
      tx_left_q   <= '0;
      tx_dest_q   <= '0;
      tx_credit_q <= CW'(`BUF_DEPTH);
      tx_o        <= 1'b0;
    end else begin
      tx_o        <= tx_fire;
      tx_credit_q <= tx_credit_q + CW'(credit_i) - CW'(tx_fire);
      case (tx_state_q)
        TX_IDLE: begin
          if (start_i) begin
            tx_addr_q  <= src_i;
            tx_left_q  <= len_i;
            tx_dest_q  <= dest_i;
            tx_state_q <= TX_HEADER;
          end
        end
        TX_HEADER: if (tx_fire) tx_state_q <= TX_READ;
        TX_READ:   if (tx_rd) tx_state_q <= TX_PAYLOAD;
        TX_PAYLOAD: begin
          if (tx_fire) begin
            tx_addr_q  <= tx_addr_q + 1'b1;
            tx_left_q  <= tx_left_q - 8'd1;
            tx_state_q <= (tx_left_q == 8'd1) ? TX_IDLE : TX_READ;
          end
        end
        default: tx_state_q <= TX_IDLE;
      endcase
    end
  end

  // header is {x, y, len}; payload comes straight from the read port
  always_ff @(posedge clock) begin
    if (tx_fire) data_o <= (tx_state_q == TX_HEADER) ? {tx_dest_q, tx_left_q} : mem_rdata_i;
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_state_q <= RX_IDLE;
      rx_addr_q  <= '0;
      rx_left_q  <= '0;
      rx_done_o  <= 1'b0;
      credit_o   <= 1'b0;
    end else begin
      credit_o <= rx_i;  // no buffering, every flit consumed on arrival
      if (rx_clear_i) rx_done_o <= 1'b0;
      case (rx_state_q)
        RX_IDLE: begin
          if (rx_i) begin
            rx_left_q  <= data_i[7:0];
            rx_addr_q  <= rx_base_i;
            rx_state_q <= RX_PAYLOAD;
          end
        end
        RX_PAYLOAD: begin
          if (rx_wr) begin
            rx_addr_q <= rx_addr_q + 1'b1;
            rx_left_q <= rx_left_q - 8'd1;
            if (rx_left_q == 8'd1) begin
              rx_state_q <= RX_IDLE;
              rx_done_o  <= 1'b1;  // set beats a same-cycle clear
            end
          end
        end
        default: rx_state_q <= RX_IDLE;
      endcase
    end
  end

endmodule

/* src/scratchpad.sv */
`timescale 1ns/1ns
`include "pe_config.svh"

module scratchpad (
  input  logic                   clock,
  input  logic                   a_req_i,
  input  logic                   a_we_i,
  input  logic [`MEM_ADDR_W-1:0] a_addr_i,
  input  logic [`FLIT_WIDTH-1:0] a_wdata_i,
  output logic [`FLIT_WIDTH-1:0] a_rdata_o,
  input  logic                   b_req_i,
  input  logic                   b_we_i,
  input  logic [`MEM_ADDR_W-1:0] b_addr_i,
  input  logic [`FLIT_WIDTH-1:0] b_wdata_i,
  output logic [`FLIT_WIDTH-1:0] b_rdata_o
);
  logic [`FLIT_WIDTH-1:0] mem_q [`MEM_DEPTH];
  logic                   a_wr;
  logic                   b_wr;

  assign a_wr = a_req_i && a_we_i;
  assign b_wr = b_req_i && b_we_i && !(a_wr && (a_addr_i == b_addr_i));  // a wins a tie

  always_ff @(posedge clock) begin
    if (a_wr) mem_q[a_addr_i] <= a_wdata_i;
    if (b_wr) mem_q[b_addr_i] <= b_wdata_i;
  end

  // read data holds until the next read on that port
  always_ff @(posedge clock) begin
    if (a_req_i && !a_we_i) a_rdata_o <= mem_q[a_addr_i];
    if (b_req_i && !b_we_i) b_rdata_o <= mem_q[b_addr_i];
  end

endmodule

/* src/mmio.sv */
`timescale 1ns/1ns
`include "pe_config.svh"

module mmio import pe_pkg::*; (
  input  logic                   clock,
  input  logic                   rst_n_i,
  input  logic                   mmio_req_i,
  input  logic                   mmio_we_i,
  input  logic [8:0]             mmio_addr_i,
  input  logic [`FLIT_WIDTH-1:0] mmio_wdata_i,
  output logic [`FLIT_WIDTH-1:0] mmio_rdata_o,
  output logic                   mmio_ack_o,
  output logic                   irq_o,
  output logic                   start_o,
  output logic [`MEM_ADDR_W-1:0] src_o,
  output logic [7:0]             len_o,
  output logic [7:0]             dest_o,
  output logic [`MEM_ADDR_W-1:0] rx_base_o,
  output logic                   rx_clear_o,
  input  logic                   busy_i,
  input  logic                   rx_done_i,
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output logic [`MEM_ADDR_W-1:0] mem_addr_o,
  output logic [`FLIT_WIDTH-1:0] mem_wdata_o,
  input  logic [`FLIT_WIDTH-1:0] mem_rdata_i
);
  logic                   reg_sel;    // addr bit 8 picks register space
  reg_addr_e              reg_addr;
  logic                   reg_wr;
  logic                   ctrl_wr;
  logic                   reg_sel_q;
  logic [`FLIT_WIDTH-1:0] reg_rdata_q;

  assign reg_sel  = mmio_addr_i[8];
  assign reg_addr = reg_addr_e'(mmio_addr_i[2:0]);
  assign reg_wr   = mmio_req_i && mmio_we_i && reg_sel;
  assign ctrl_wr  = reg_wr && (reg_addr == REG_CTRL);

  assign start_o      = ctrl_wr && mmio_wdata_i[0] && !busy_i;  // dropped while busy
  assign rx_clear_o   = ctrl_wr && mmio_wdata_i[1];
  assign irq_o        = rx_done_i;
  assign mmio_rdata_o = reg_sel_q ? reg_rdata_q : mem_rdata_i;

  assign mem_req_o   = mmio_req_i && !reg_sel;
  assign mem_we_o    = mmio_we_i;
  assign mem_addr_o  = mmio_addr_i[`MEM_ADDR_W-1:0];
  assign mem_wdata_o = mmio_wdata_i;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mmio_ack_o <= 1'b0;
      reg_sel_q  <= 1'b0;
      src_o      <= '0;
      len_o      <= '0;
      dest_o     <= '0;
      rx_base_o  <= '0;
    end else begin
      mmio_ack_o <= mmio_req_i;
      if (mmio_req_i) reg_sel_q <= reg_sel;
      if (reg_wr) begin
        case (reg_addr)
          REG_SRC:     src_o     <= mmio_wdata_i[`MEM_ADDR_W-1:0];
          REG_LEN:     len_o     <= mmio_wdata_i[7:0];
          REG_DEST:    dest_o    <= mmio_wdata_i[7:0];
          REG_RX_BASE: rx_base_o <= mmio_wdata_i[`MEM_ADDR_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (mmio_req_i && reg_sel) begin
      case (reg_addr)
        REG_SRC:     reg_rdata_q <= `FLIT_WIDTH'(src_o);
        REG_LEN:     reg_rdata_q <= `FLIT_WIDTH'(len_o);
        REG_DEST:    reg_rdata_q <= `FLIT_WIDTH'(dest_o);
        REG_CTRL:    reg_rdata_q <= `FLIT_WIDTH'({rx_done_i, busy_i});
        REG_RX_BASE: reg_rdata_q <= `FLIT_WIDTH'(rx_base_o);
        default:     reg_rdata_q <= '0;
      endcase
    end
  end

endmodule

/* src/pe.sv */
`timescale 1ns/1ns
`include "pe_config.svh"

module pe (
  input  logic                        clock,
  input  logic                        rst_n_i,
  output logic [3:0]                  tx_o,
  output logic [3:0][`FLIT_WIDTH-1:0] data_o,
  input  logic [3:0]                  credit_i,
  input  logic [3:0]                  rx_i,
  input  logic [3:0][`FLIT_WIDTH-1:0] data_i,
  output logic [3:0]                  credit_o,
  input  logic                        mmio_req_i,
  input  logic                        mmio_we_i,
  input  logic [8:0]                  mmio_addr_i,
  input  logic [`FLIT_WIDTH-1:0]      mmio_wdata_i,
  output logic [`FLIT_WIDTH-1:0]      mmio_rdata_o,
  output logic                        mmio_ack_o,
  output logic                        irq_o
);
  logic [4:0]                  r_tx;
  logic [4:0][`FLIT_WIDTH-1:0] r_data;
  logic [4:0]                  r_credit;
  logic                        l_tx;      // ddma into router local port
  logic [`FLIT_WIDTH-1:0]      l_data;
  logic                        l_credit;  // ddma credit back to router
  logic                        start, rx_clear, busy, rx_done;
  logic [`MEM_ADDR_W-1:0]      src, rx_base;
  logic [7:0]                  len, dest;
  logic                        a_req, a_we, b_req, b_we;
  logic [`MEM_ADDR_W-1:0]      a_addr, b_addr;
  logic [`FLIT_WIDTH-1:0]      a_wdata, a_rdata, b_wdata, b_rdata;

  assign tx_o     = r_tx[3:0];
  assign data_o   = r_data[3:0];
  assign credit_o = r_credit[3:0];

  router u_router (
    .clock (clock), .rst_n_i (rst_n_i),
    .rx_i ({l_tx, rx_i}), .data_i ({l_data, data_i}), .credit_o (r_credit),
    .tx_o (r_tx), .data_o (r_data), .credit_i ({l_credit, credit_i})
  );

  ddma u_ddma (
    .clock (clock), .rst_n_i (rst_n_i),
    .start_i (start), .src_i (src), .len_i (len), .dest_i (dest), .rx_base_i (rx_base),
    .busy_o (busy), .rx_done_o (rx_done), .rx_clear_i (rx_clear),
    .tx_o (l_tx), .data_o (l_data), .credit_i (r_credit[4]),
    .rx_i (r_tx[4]), .data_i (r_data[4]), .credit_o (l_credit),
    .mem_req_o (a_req), .mem_we_o (a_we), .mem_addr_o (a_addr),
    .mem_wdata_o (a_wdata), .mem_rdata_i (a_rdata)
  );

  scratchpad u_scratchpad (
    .clock (clock),
    .a_req_i (a_req), .a_we_i (a_we), .a_addr_i (a_addr),
    .a_wdata_i (a_wdata), .a_rdata_o (a_rdata),
    .b_req_i (b_req), .b_we_i (b_we), .b_addr_i (b_addr),
    .b_wdata_i (b_wdata), .b_rdata_o (b_rdata)
  );

  mmio u_mmio (
    .clock (clock), .rst_n_i (rst_n_i),
    .mmio_req_i (mmio_req_i), .mmio_we_i (mmio_we_i), .mmio_addr_i (mmio_addr_i),
    .mmio_wdata_i (mmio_wdata_i), .mmio_rdata_o (mmio_rdata_o), .mmio_ack_o (mmio_ack_o),
    .irq_o (irq_o), .start_o (start), .src_o (src), .len_o (len), .dest_o (dest),
    .rx_base_o (rx_base), .rx_clear_o (rx_clear), .busy_i (busy), .rx_done_i (rx_done),
    .mem_req_o (b_req), .mem_we_o (b_we), .mem_addr_o (b_addr),
    .mem_wdata_o (b_wdata), .mem_rdata_i (b_rdata)
  );

endmodule

/* testbench/pe_properties.sv */
`timescale 1ns/1ns
`include "pe_config.svh"

module pe_properties import pe_pkg::*; (
  input logic       clock,
  input logic       rst_n_i,
  input logic [4:0] tx_o,
  input logic [4:0] credit_i,
  input logic [4:0] locked_q,
  input logic [2:0] owner_q [5],
  input port_e      route [5],
  input logic [2:0] credit_q [5]
);
  logic [3:0] in_flight_q [5];  // flits sent, credit not back yet

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int o = 0; o < 5; o++) in_flight_q[o] <= '0;
    end else begin
      for (int o = 0; o < 5; o++) begin
        in_flight_q[o] <= in_flight_q[o] + 4'(tx_o[o]) - 4'(credit_i[o]);
      end
    end
  end

  for (genvar o = 0; o < 5; o++) begin : g_out
    // a flit only goes out against a free downstream slot
    a_credit_gate: assert property (@(posedge clock) disable iff (!rst_n_i)
      tx_o[o] |-> in_flight_q[o] < `BUF_DEPTH)
      else $error("output %0d sent a flit with no credit", o);

    a_credit_max: assert property (@(posedge clock) disable iff (!rst_n_i)
      credit_q[o] <= `BUF_DEPTH)
      else $error("output %0d credit count above buffer depth", o);

    // wormhole lock stays with the packet that took it
    a_owner_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
      locked_q[o] |-> route[owner_q[o]] == port_e'(o))
      else $error("output %0d changed owner mid-packet", o);
  end

endmodule

/* testbench/pe_checker.sv */
`timescale 1ns/1ns
`include "pe_config.svh"

module pe_checker (
  input logic                        clock,
  input logic                        rst_n_i,
  input logic [3:0]                  tx_o,
  input logic [3:0][`FLIT_WIDTH-1:0] data_o
);
  localparam int NSLOT = 16;

  logic [`FLIT_WIDTH-1:0] exp_flit [NSLOT][257];  // header then payload
  int exp_len [NSLOT];
  int exp_port [NSLOT];
  bit exp_open [NSLOT];
  int n_exp = 0;
  int fill_idx = 0;
  int cur [4] = '{-1, -1, -1, -1};  // slot being received per port
  int idx [4];
  int outstanding = 0;
  int errors = 0;
  int passes = 0;

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      errors++;
      $display("Fail %0t %s expected %h got %h", $time, name, exp, got);
    end else begin
      passes++;
    end
  endtask

  task automatic add_packet(input int port, input logic [`FLIT_WIDTH-1:0] hdr);
    exp_port[n_exp]    = port;
    exp_len[n_exp]     = hdr[7:0];
    exp_open[n_exp]    = 1'b1;
    exp_flit[n_exp][0] = hdr;
    fill_idx           = 1;
    n_exp++;
    outstanding++;
  endtask

  task automatic add_flit(input logic [`FLIT_WIDTH-1:0] word);
    exp_flit[n_exp-1][fill_idx] = word;
    fill_idx++;
  endtask

  task automatic report_missing();
    for (int i = 0; i < n_exp; i++) begin
      if (exp_open[i]) begin
        errors++;
        $display("packet with header %h never arrived complete on port %0d",
                 exp_flit[i][0], exp_port[i]);
        exp_open[i] = 1'b0;
      end
    end
    outstanding = 0;
    for (int p = 0; p < 4; p++) cur[p] = -1;
  endtask

  task automatic take_flit(input int p, input logic [`FLIT_WIDTH-1:0] d);
    int s;
    int first;
    s = -1;
    first = -1;
    if (cur[p] < 0) begin
      for (int i = 0; i < n_exp; i++) begin
        if (exp_open[i] && exp_port[i] == p) begin
          if (first < 0) first = i;
          if (s < 0 && exp_flit[i][0] == d) s = i;
        end
      end
      if (s >= 0) begin
        cur[p] = s;
        idx[p] = 1;
        passes++;
      end else if (first >= 0) begin
        check_value($sformatf("data_o[%0d]", p), exp_flit[first][0], d);
      end else begin
        errors++;
        $display("unexpected packet with header %h on port %0d at %0t", d, p, $time);
      end
    end else begin
      s = cur[p];
      check_value($sformatf("data_o[%0d]", p), exp_flit[s][idx[p]], d);
      idx[p]++;
      if (idx[p] > exp_len[s]) begin
        exp_open[s] = 1'b0;
        outstanding--;
        cur[p] = -1;
      end
    end
  endtask

  // link outputs settle well before the falling edge
  always @(negedge clock) begin
    if (rst_n_i) begin
      for (int p = 0; p < 4; p++) begin
        if (tx_o[p]) take_flit(p, data_o[p]);
      end
    end
  end

endmodule

/* testbench/tb_pe.sv */
`timescale 1ns/1ns
`include "pe_config.svh"

module tb_pe import pe_pkg::*; ();
  localparam int NROWS = 8;

  typedef enum {KIND_INJECT, KIND_CPU_SEND, KIND_PAIR} kind_e;

  logic                        clock;
  logic                        rst_n_i;
  logic [3:0]                  tx_o, credit_i, rx_i, credit_o;
  logic [3:0][`FLIT_WIDTH-1:0] data_o, data_i;
  logic                        mmio_req_i, mmio_we_i, mmio_ack_o, irq_o;
  logic [8:0]                  mmio_addr_i;
  logic [`FLIT_WIDTH-1:0]      mmio_wdata_i, mmio_rdata_o;

  kind_e                  row_kind [NROWS];
  port_e                  row_in [NROWS];
  logic [7:0]             row_dest [NROWS];
  int                     row_len [NROWS];
  int                     row_stall [NROWS];
  port_e                  row_exp [NROWS];
  logic [`FLIT_WIDTH-1:0] row_pay [NROWS][16];  // second packet of a pair from 8

  int     in_cred [4];     // credits toward the dut input links
  int     pend [4];        // flits out with credit not yet returned
  int     peak [4];
  int     stall_left [4];
  int     cycles = 0;
  int     limit = 100000;
  integer seed = 24;

  pe u_pe (.*);

  pe_checker u_chk (.clock(clock), .rst_n_i(rst_n_i), .tx_o(tx_o), .data_o(data_o));

  bind router pe_properties u_props (
    .clock(clock), .rst_n_i(rst_n_i), .tx_o(tx_o), .credit_i(credit_i),
    .locked_q(locked_q), .owner_q(owner_q), .route(route), .credit_q(credit_q)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Test FAILED");
      $finish;
    end
  end

  // neighbor nodes: count flits and credits at the falling edge
  always @(negedge clock) begin
    for (int p = 0; p < 4; p++) begin
      if (rst_n_i && credit_o[p]) in_cred[p]++;
      if (rst_n_i && tx_o[p]) begin
        pend[p]++;
        if (pend[p] > peak[p]) peak[p] = pend[p];
      end
    end
  end

  always @(posedge clock) begin
    #2;
    for (int p = 0; p < 4; p++) begin
      if (stall_left[p] > 0) begin
        stall_left[p]--;
        credit_i[p] = 1'b0;
      end else if (pend[p] > 0) begin
        credit_i[p] = 1'b1;
        pend[p]--;
      end else begin
        credit_i[p] = 1'b0;
      end
    end
  end

  // xy rule against node 1,1
  function automatic port_e route_of(input logic [7:0] dest);
    if (dest[7:4] > `NODE_X) return PORT_EAST;
    if (dest[7:4] < `NODE_X) return PORT_WEST;
    if (dest[3:0] > `NODE_Y) return PORT_NORTH;
    if (dest[3:0] < `NODE_Y) return PORT_SOUTH;
    return PORT_LOCAL;
  endfunction

  function automatic logic [8:0] reg_a(input reg_addr_e a);
    return {1'b1, 5'b0, a};
  endfunction

  task automatic set_row(input int r, input kind_e k, input port_e in, input logic [7:0] dest,
                         input int len, input int stall);
    row_kind[r]  = k;
    row_in[r]    = in;
    row_dest[r]  = dest;
    row_len[r]   = len;
    row_stall[r] = stall;
    row_exp[r]   = route_of(dest);
    for (int i = 0; i < 16; i++) row_pay[r][i] = 16'($random(seed));
  endtask

  task automatic build_table();
    set_row(0, KIND_INJECT,   PORT_EAST,  8'h01, 3, 0);
    set_row(1, KIND_INJECT,   PORT_WEST,  8'h32, 2, 0);
    set_row(2, KIND_INJECT,   PORT_NORTH, 8'h10, 4, 0);
    set_row(3, KIND_INJECT,   PORT_SOUTH, 8'h13, 1, 0);
    set_row(4, KIND_INJECT,   PORT_WEST,  8'h11, 4, 0);   // local delivery
    set_row(5, KIND_CPU_SEND, PORT_LOCAL, 8'h21, 5, 0);
    set_row(6, KIND_INJECT,   PORT_WEST,  8'h21, 8, 20);  // back-pressure
    set_row(7, KIND_PAIR,     PORT_NORTH, 8'h01, 3, 0);   // second one from south
  endtask

  task automatic inject(input int p, input logic [7:0] dest, input int len,
                        input int r, input int off);
    logic [`FLIT_WIDTH-1:0] flit;
    for (int k = 0; k <= len; k++) begin
      flit = (k == 0) ? {dest, 8'(len)} : row_pay[r][off+k-1];
      @(posedge clock);
      #2;
      while (in_cred[p] == 0) begin
        rx_i[p] = 1'b0;
        @(posedge clock);
        #2;
      end
      rx_i[p]   = 1'b1;
      data_i[p] = flit;
      in_cred[p]--;
    end
    @(posedge clock);
    #2;
    rx_i[p] = 1'b0;
  endtask

  task automatic expect_row(input int r, input int port, input int len, input int off);
    u_chk.add_packet(port, {row_dest[r], 8'(len)});
    for (int k = 0; k < len; k++) u_chk.add_flit(row_pay[r][off+k]);
  endtask

  task automatic cpu_write(input logic [8:0] addr, input logic [`FLIT_WIDTH-1:0] wdata);
    @(posedge clock);
    #2;
    mmio_req_i   = 1'b1;
    mmio_we_i    = 1'b1;
    mmio_addr_i  = addr;
    mmio_wdata_i = wdata;
    @(posedge clock);
    #2;
    mmio_req_i = 1'b0;
    mmio_we_i  = 1'b0;
    u_chk.check_value("mmio_ack_o", 1, mmio_ack_o);
  endtask

  task automatic cpu_read(input logic [8:0] addr, output logic [`FLIT_WIDTH-1:0] rdata);
    @(posedge clock);
    #2;
    mmio_req_i  = 1'b1;
    mmio_we_i   = 1'b0;
    mmio_addr_i = addr;
    @(posedge clock);
    #2;
    mmio_req_i = 1'b0;
    u_chk.check_value("mmio_ack_o", 1, mmio_ack_o);
    rdata = mmio_rdata_o;
  endtask

  task automatic wait_drained(input int bound);
    int n;
    n = 0;
    while (u_chk.outstanding != 0 && n < bound) begin
      @(posedge clock);
      n++;
    end
    if (u_chk.outstanding != 0) u_chk.report_missing();
  endtask

  task automatic run_local(input int r);
    logic [`FLIT_WIDTH-1:0] d;
    int n;
    n = 0;
    cpu_write(reg_a(REG_RX_BASE), 16'h0040);
    inject(row_in[r], row_dest[r], row_len[r], r, 0);
    while (!irq_o && n < 50) begin
      @(posedge clock);
      #2;
      n++;
    end
    u_chk.check_value("irq_o", 1, irq_o);
    for (int k = 0; k < row_len[r]; k++) begin
      cpu_read(9'(8'h40 + k), d);
      u_chk.check_value("mmio_rdata_o", row_pay[r][k], d);
    end
    cpu_write(reg_a(REG_CTRL), 16'h0002);  // clear rx_done
    u_chk.check_value("irq_o", 0, irq_o);
  endtask

  task automatic run_cpu_send(input int r);
    logic [`FLIT_WIDTH-1:0] d;
    int n;
    n = 0;
    for (int k = 0; k < row_len[r]; k++) cpu_write(9'(8'h10 + k), row_pay[r][k]);
    cpu_write(reg_a(REG_SRC), 16'h0010);
    cpu_write(reg_a(REG_LEN), 16'(row_len[r]));
    cpu_write(reg_a(REG_DEST), 16'(row_dest[r]));
    expect_row(r, row_exp[r], row_len[r], 0);
    cpu_write(reg_a(REG_CTRL), 16'h0001);
    wait_drained((row_len[r] + 1) * 4 + 50);
    d = 16'h0001;
    while (d[0] && n < 20) begin
      cpu_read(reg_a(REG_CTRL), d);
      n++;
    end
    u_chk.check_value("busy", 0, d[0]);
  endtask

  initial begin
    int err0;
    int p2;
    rst_n_i      = 1'b0;
    rx_i         = '0;
    data_i       = '0;
    credit_i     = '0;
    mmio_req_i   = 1'b0;
    mmio_we_i    = 1'b0;
    mmio_addr_i  = '0;
    mmio_wdata_i = '0;
    for (int p = 0; p < 4; p++) begin
      in_cred[p]    = `BUF_DEPTH;
      pend[p]       = 0;
      peak[p]       = 0;
      stall_left[p] = 0;
    end
    build_table();
    limit = 16 + 200;
    for (int r = 0; r < NROWS; r++) limit += (row_len[r] + 1) * 4 + row_stall[r];

    repeat (16) @(posedge clock);
    #2;
    rst_n_i = 1'b1;
    // reset state, before any stimulus
    u_chk.check_value("tx_o", 0, tx_o);
    u_chk.check_value("credit_o", 0, credit_o);
    u_chk.check_value("irq_o", 0, irq_o);
    u_chk.check_value("mmio_ack_o", 0, mmio_ack_o);

    for (int r = 0; r < NROWS; r++) begin
      err0 = u_chk.errors;
      for (int p = 0; p < 4; p++) peak[p] = 0;
      if (row_exp[r] != PORT_LOCAL) stall_left[int'(row_exp[r])] = row_stall[r];
      case (row_kind[r])
        KIND_CPU_SEND: run_cpu_send(r);
        KIND_PAIR: begin
          p2 = (int'(row_in[r]) + 1) % 4;
          expect_row(r, row_exp[r], row_len[r], 0);
          expect_row(r, row_exp[r], row_len[r] + 1, 8);
          fork
            inject(row_in[r], row_dest[r], row_len[r], r, 0);
            inject(p2, row_dest[r], row_len[r] + 1, r, 8);
          join
          wait_drained((row_len[r] * 2 + 3) * 4 + 50);
        end
        default: begin
          if (row_exp[r] == PORT_LOCAL) begin
            run_local(r);
          end else begin
            expect_row(r, row_exp[r], row_len[r], 0);
            inject(row_in[r], row_dest[r], row_len[r], r, 0);
            wait_drained((row_len[r] + 1) * 4 + row_stall[r] + 50);
          end
        end
      endcase
      if (row_stall[r] > 0) begin
        // only a buffer's worth may leave while credits are held
        u_chk.check_value("flits sent while stalled",
                          (row_len[r] + 1 < `BUF_DEPTH) ? row_len[r] + 1 : `BUF_DEPTH,
                          peak[int'(row_exp[r])]);
      end
      $display("row %0d %s to %02h len %0d: %s", r, row_kind[r].name(), row_dest[r],
               row_len[r], (u_chk.errors == err0) ? "ok" : "failed");
    end

    $display("checks passed %0d failed %0d", u_chk.passes, u_chk.errors);
    if (u_chk.errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+common
common/pe_pkg.sv
router/router_input_buffer.sv
router/router.sv
src/ddma.sv
src/scratchpad.sv
src/mmio.sv
src/pe.sv
testbench/pe_properties.sv
testbench/pe_checker.sv
testbench/tb_pe.sv

/* Bender.yml */
package:
  name: pe

sources:
  - include_dirs:
      - common
    files:
      - common/pe_pkg.sv
      - router/router_input_buffer.sv
      - router/router.sv
      - src/ddma.sv
      - src/scratchpad.sv
      - src/mmio.sv
      - src/pe.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/pe_properties.sv
      - testbench/pe_checker.sv
      - testbench/tb_pe.sv
